/* dv/dma_probe_props.sv */
module dma_probe_props import per_bus_pkg::*, dma_pkg::*; #(
  parameter logic [PER_AW:0] BASE_ADDR = 15'h0070,
  parameter int              RAM_AW    = 8
) (
  input logic              mclk,
  input logic              puc_rst,
  input logic [PER_AW-1:0] per_addr,
  input logic [PER_DW-1:0] per_din,
  input logic              per_en,
  input logic [1:0]        per_we,
  input logic [PER_DW-1:0] per_dout,
  input logic [RAM_AW-1:0] cpu_addr,
  input logic              cpu_en,
  input logic [1:0]        cpu_we,
  input logic [15:0]       cpu_din,
  input logic [15:0]       cpu_dout,
  input logic [DMA_AW-1:0] dma_addr,
  input logic              dma_en
);

  // Word addresses of the probe registers
  localparam logic [PER_AW-1:0] ADDR_WA  = PER_AW'((BASE_ADDR + REG_ADDR_OFS) >> 1);
  localparam logic [PER_AW-1:0] CNT_WA   = PER_AW'((BASE_ADDR + REG_CNT_OFS) >> 1);
  localparam logic [PER_AW-1:0] TRACE_WA = PER_AW'((BASE_ADDR + REG_TRACE_OFS) >> 1);

  int                fail_cnt = 0;     // Failed assertion count
  logic              wr_any;
  logic [PER_DW-1:0] m_addr;           // Shadow ADDR
  logic [PER_DW-1:0] m_cnt;            // Shadow delay
  int                m_burst;          // Burst cycles left
  trace_t            m_trace;          // Shadow stall pattern
  logic              exp_en;
  logic [PER_DW-1:0] exp_dout;
  logic [15:0]       m_mem [1 << RAM_AW];
  bit                m_vld [1 << RAM_AW];  // Word written at least once
  logic              rd_chk;
  logic [15:0]       rd_exp;

  assign wr_any = per_en & |per_we;
  assign exp_en = (m_burst != 0);

  //==========================================================================
  // Register, delay and trace model
  //==========================================================================

  always @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      m_addr  <= '0;
      m_cnt   <= '0;
      m_burst <= 0;
      m_trace <= '0;
    end else begin
      if (wr_any && per_addr == ADDR_WA) m_addr <= per_din;
      if (exp_en) m_trace <= {m_trace[PROBE_LEN-2:0], cpu_en & (cpu_addr[0] == m_addr[0])};
      if (wr_any && per_addr == CNT_WA) begin
        m_cnt   <= per_din;            // Also kills a running burst
        m_burst <= 0;
      end else begin
        if (m_cnt != '0) m_cnt <= m_cnt - 1'b1;
        if (m_cnt == 16'd1) m_burst <= PROBE_LEN;
        else if (m_burst != 0) m_burst <= m_burst - 1;
      end
    end
  end

  always_comb begin
    exp_dout = '0;                     // Idle, write or unmapped
    if (per_en && per_we == 2'b00) begin
      if (per_addr == ADDR_WA) exp_dout = m_addr;
      else if (per_addr == CNT_WA) exp_dout = m_cnt;
      else if (per_addr == TRACE_WA) exp_dout = PER_DW'(m_trace);
    end
  end

  // RAM shadow with byte lanes
  always @(posedge mclk) begin
    rd_chk <= 1'b0;
    if (cpu_en && cpu_we != 2'b00) begin
      if (cpu_we[0]) m_mem[cpu_addr][7:0] <= cpu_din[7:0];
      if (cpu_we[1]) m_mem[cpu_addr][15:8] <= cpu_din[15:8];
      m_vld[cpu_addr] <= 1'b1;
    end else if (cpu_en) begin
      rd_chk <= m_vld[cpu_addr];       // Only known words are compared
      rd_exp <= m_mem[cpu_addr];
    end
  end

  //==========================================================================
  // Assertions
  //==========================================================================

  a_dma_en: assert property (@(posedge mclk) disable iff (puc_rst) dma_en == exp_en)
    else begin
      $error("Error at %0t: dma_en = %b, expected %b", $time, $sampled(dma_en), $sampled(exp_en));
      fail_cnt++;
    end

  a_dma_addr: assert property (@(posedge mclk) disable iff (puc_rst)
    dma_en |-> dma_addr == m_addr[DMA_AW-1:0])
    else begin
      $error("Error at %0t: dma_addr = %h, expected %h", $time, $sampled(dma_addr),
             $sampled(m_addr[DMA_AW-1:0]));
      fail_cnt++;
    end

  a_per_dout: assert property (@(posedge mclk) disable iff (puc_rst) per_dout == exp_dout)
    else begin
      $error("Error at %0t: per_dout = %h, expected %h", $time, $sampled(per_dout),
             $sampled(exp_dout));
      fail_cnt++;
    end

  a_cpu_dout: assert property (@(posedge mclk) disable iff (puc_rst) rd_chk |-> cpu_dout == rd_exp)
    else begin
      $error("Error at %0t: cpu_dout = %h, expected %h", $time, $sampled(cpu_dout),
             $sampled(rd_exp));
      fail_cnt++;
    end

endmodule

/* dv/dma_probe_tb.sv */
module dma_probe_tb import per_bus_pkg::*, dma_pkg::*; ();

  localparam logic [PER_AW:0] BASE_ADDR = 15'h0070;
  localparam int              RAM_AW    = 8;
  localparam int              TIMEOUT   = 600;  // 8 bursts of 40 cycles plus register phases

  logic              mclk;
  logic              puc_rst;
  logic [PER_AW-1:0] per_addr;
  logic [PER_DW-1:0] per_din;
  logic              per_en;
  logic [1:0]        per_we;
  logic [PER_DW-1:0] per_dout;
  logic [RAM_AW-1:0] cpu_addr;
  logic              cpu_en;
  logic [1:0]        cpu_we;
  logic [15:0]       cpu_din;
  logic [15:0]       cpu_dout;
  logic [DMA_AW-1:0] dma_addr;
  logic              dma_en;

  int unsigned lcg_state = 52553;
  int          cycle_cnt = 0;
  int          seq_errs  = 0;      // Bursts that never showed up

  dma_probe_top #(
    .BASE_ADDR (BASE_ADDR),
    .DEC_WD    (3),
    .RAM_AW    (RAM_AW)
  ) dut_i (.*);

  bind dma_probe_top dma_probe_props #(.BASE_ADDR(BASE_ADDR), .RAM_AW(RAM_AW)) props_i (.*);

  //==========================================================================
  // Clock, timeout and helpers
  //==========================================================================

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;        // Low bits of an LCG are weak
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'(lcg_next() % (hi - lo + 1));
  endfunction

  // One bus cycle at byte offset ofs from the base, entered right after an edge
  task automatic per_access(int ofs, logic [1:0] we, logic [15:0] data);
    per_en   <= 1'b1;
    per_we   <= we;
    per_addr <= PER_AW'((BASE_ADDR + ofs) >> 1);
    per_din  <= data;
    @(posedge mclk);
    per_en <= 1'b0;
    per_we <= 2'b00;
  endtask

  task automatic cpu_access(logic [RAM_AW-1:0] addr, logic [1:0] we, logic [15:0] data);
    cpu_en   <= 1'b1;
    cpu_addr <= addr;
    cpu_we   <= we;
    cpu_din  <= data;
    @(posedge mclk);
    cpu_en <= 1'b0;
    cpu_we <= 2'b00;
  endtask

  // Random CPU reads until dma_en rises, and falls again unless rise_only
  task automatic wait_burst(bit rise_only);
    int          n;
    int unsigned r;
    bit          seen;
    bit          done;
    seen = 1'b0;
    done = 1'b0;
    for (n = 0; n < 60 && !done; n++) begin
      r = lcg_next();
      cpu_en   <= r[0];
      cpu_addr <= RAM_AW'(r >> 1);
      @(negedge mclk);             // Outputs settled here
      seen = seen | dma_en;
      done = seen & (rise_only | ~dma_en);
      @(posedge mclk);
    end
    cpu_en <= 1'b0;
    if (!done) begin
      seq_errs++;
      $display("At %0t a DMA burst did not %s within 60 cycles", $time,
               rise_only ? "start" : "finish");
    end
  endtask

  //==========================================================================
  // Stimulus
  //==========================================================================

  initial begin
    int total;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    cpu_addr = '0;
    cpu_en   = 1'b0;
    cpu_we   = 2'b00;
    cpu_din  = '0;
    puc_rst  = 1'b1;
    repeat (8) @(posedge mclk);
    puc_rst <= 1'b0;
    @(posedge mclk);

    per_access(REG_ADDR_OFS, 2'b00, '0);   // All zero out of reset
    per_access(REG_CNT_OFS, 2'b00, '0);
    per_access(REG_TRACE_OFS, 2'b00, '0);

    // ADDR readback, then a hole in the window and an address past it
    per_access(REG_ADDR_OFS, 2'b11, 16'hB3C5);
    per_access(REG_ADDR_OFS, 2'b00, '0);
    per_access(6, 2'b00, '0);
    per_access(8, 2'b11, 16'hFFFF);        // Outside, ADDR must keep its value
    per_access(8, 2'b00, '0);
    per_access(REG_ADDR_OFS, 2'b00, '0);

    // CPU port, full words first so both lanes are known
    cpu_access(8'h12, 2'b11, 16'hA5C3);
    cpu_access(8'h13, 2'b11, 16'h3C5A);
    cpu_access(8'h12, 2'b01, 16'hFF00);
    cpu_access(8'h13, 2'b10, 16'h00FF);
    cpu_access(8'h12, 2'b00, '0);
    cpu_access(8'h13, 2'b00, '0);

    // Bursts with random target, delay and CPU traffic
    repeat (6) begin
      per_access(REG_ADDR_OFS, 2'b11, 16'(lcg_next()));
      per_access(REG_CNT_OFS, 2'b11, 16'(rand_range(1, 20)));
      wait_burst(1'b0);
      per_access(REG_TRACE_OFS, 2'b00, '0);
      per_access(REG_CNT_OFS, 2'b00, '0);
    end

    // Abort in mid burst, then a full one after the new delay
    per_access(REG_CNT_OFS, 2'b11, 16'(rand_range(1, 20)));
    wait_burst(1'b1);
    repeat (rand_range(2, 10)) @(posedge mclk);
    per_access(REG_CNT_OFS, 2'b11, 16'(rand_range(1, 20)));
    wait_burst(1'b0);
    per_access(REG_TRACE_OFS, 2'b00, '0);

    // Zero parks the engine
    per_access(REG_CNT_OFS, 2'b11, 16'd10);
    repeat (4) @(posedge mclk);
    per_access(REG_CNT_OFS, 2'b00, '0);    // Delay left in mid count
    per_access(REG_CNT_OFS, 2'b11, 16'd0);
    repeat (20) @(posedge mclk);

    total = dut_i.props_i.fail_cnt + seq_errs;
    $display("Finished after %0d cycles: %0d assertion failures, %0d burst errors",
             cycle_cnt, dut_i.props_i.fail_cnt, seq_errs);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* flist.f */
src/per_bus_pkg.sv
src/dma_pkg.sv
src/dma_if.sv
src/probe_cfg_if.sv
src/dma_probe_regs.sv
src/dma_probe_engine.sv
src/banked_ram.sv
src/dma_probe_top.sv
dv/dma_probe_props.sv
dv/dma_probe_tb.sv

/* src/banked_ram.sv */
module banked_ram import dma_pkg::*; #(
  parameter int RAM_AW = 8         // Word address width, bit 0 picks the bank
) (
  input  logic              mclk,
  input  logic              puc_rst,
  input  logic [RAM_AW-1:0] cpu_addr,
  input  logic              cpu_en,
  input  logic [1:0]        cpu_we,   // Byte enables, zero for a read
  input  logic [15:0]       cpu_din,
  output logic [15:0]       cpu_dout,
  dma_if.ram                dma
);

  localparam int ROW_AW = RAM_AW - 1;     // Row address inside one bank
  localparam int DEPTH  = 1 << ROW_AW;    // Words per bank

  logic              cpu_bank;
  logic [ROW_AW-1:0] cpu_row;
  logic [15:0]       bank_rdata [2];      // Row contents of each bank
  logic              cpu_read;

  assign cpu_bank = cpu_addr[0];
  assign cpu_row  = cpu_addr[RAM_AW-1:1];
  assign cpu_read = cpu_en & ~|cpu_we;

  //==========================================================================
  // Banks
  //==========================================================================

  // Even words in bank 0, odd words in bank 1
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [15:0] mem [DEPTH];
    logic        bank_wr;

    assign bank_wr = cpu_en & (cpu_bank == 1'(b));

    // Byte lanes written separately
    always_ff @(posedge mclk) begin
      if (bank_wr & cpu_we[0]) begin
        mem[cpu_row][7:0]  <= cpu_din[7:0];
      end
      if (bank_wr & cpu_we[1]) begin
        mem[cpu_row][15:8] <= cpu_din[15:8];
      end
    end

    assign bank_rdata[b] = mem[cpu_row];
  end

  //==========================================================================
  // CPU read port
  //==========================================================================

  // Data one cycle after the read, held until the next read
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cpu_dout <= '0;
    end else if (cpu_read) begin
      cpu_dout <= bank_rdata[cpu_bank];
    end
  end

  //==========================================================================
  // DMA arbitration
  //==========================================================================

  // CPU always wins its bank
  // Stall is flagged whether or not the DMA side asks, the engine
  // only samples it while dma.en is high
  assign dma.ready = ~(cpu_en & (cpu_bank == dma.addr[0]));

endmodule

/* src/dma_if.sv */
interface dma_if import dma_pkg::*; ();

  logic [DMA_AW-1:0] addr;         // Word address of the read request
  logic              en;           // Request active
  logic              ready;        // Low on a same bank CPU conflict

  // Request side
  modport engine (
    output addr,
    output en,
    input  ready
  );

  // Memory side, ready is combinational from this cycle's inputs
  modport ram (
    input  addr,
    input  en,
    output ready
  );

endinterface

/* src/dma_pkg.sv */
package dma_pkg;

  //==========================================================================
  // DMA port and probe burst
  //==========================================================================

  localparam int DMA_AW = 15;      // Word address, covers the full 64 KB space

  // Sampled cycles per burst
  localparam int PROBE_LEN = 16;   // One trace bit each

  // Stall flags of one burst
  // Bit 0 holds the newest sample, the oldest ends up in the top bit
  typedef logic [PROBE_LEN-1:0] trace_t;

endpackage

/* src/dma_probe_engine.sv */
module dma_probe_engine import dma_pkg::*; (
  input  logic         mclk,
  input  logic         puc_rst,
  probe_cfg_if.engine  cfg,
  dma_if.engine        dma
);

  localparam int BW = $clog2(PROBE_LEN + 1);  // Holds PROBE_LEN down to 0

  logic [BW-1:0] burst_cnt;        // Burst cycles left, includes the current one
  logic          burst_start;      // Delay runs out at this edge

  //==========================================================================
  // Start delay
  //==========================================================================

  // Last step of the count, unless a new value is written right now
  assign burst_start = (cfg.cnt_remaining == 'd1) & ~cfg.cnt_load;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cfg.cnt_remaining <= '0;
    end else if (cfg.cnt_load) begin
      cfg.cnt_remaining <= cfg.cnt_value;  // Zero parks the engine
    end else if (cfg.cnt_remaining != '0) begin
      cfg.cnt_remaining <= cfg.cnt_remaining - 1'b1;
    end
  end

  //==========================================================================
  // Burst sequencer
  //==========================================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      dma.en    <= 1'b0;
      dma.addr  <= '0;
      burst_cnt <= '0;
    end else if (cfg.cnt_load) begin
      dma.en    <= 1'b0;           // Abort, the delay starts over
      burst_cnt <= '0;
    end else if (burst_start) begin
      dma.en    <= 1'b1;
      dma.addr  <= cfg.target_addr;  // Held for the whole burst
      burst_cnt <= BW'(PROBE_LEN);
    end else if (dma.en) begin
      burst_cnt <= burst_cnt - 1'b1;
      if (burst_cnt == 'd1) begin
        dma.en <= 1'b0;            // Closing cycle of the burst
      end
    end
  end

  //==========================================================================
  // Trace capture
  //==========================================================================

  // One flag per request cycle, also on the cycle an abort hits
  // A stalled request is dropped, not retried
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cfg.trace <= '0;
    end else if (dma.en) begin
      cfg.trace <= {cfg.trace[PROBE_LEN-2:0], ~dma.ready};  // Newest in bit 0
    end
  end

endmodule

/* src/dma_probe_regs.sv */
module dma_probe_regs import per_bus_pkg::*, dma_pkg::*; #(
  parameter logic [PER_AW:0] BASE_ADDR = 15'h0070,  // Byte address, aligned to DEC_WD
  parameter int              DEC_WD    = 3          // Address bits used by the decoder
) (
  input  logic              mclk,
  input  logic              puc_rst,
  input  logic [PER_AW-1:0] per_addr,
  input  logic [PER_DW-1:0] per_din,
  input  logic              per_en,
  input  logic [1:0]        per_we,
  output logic [PER_DW-1:0] per_dout,
  probe_cfg_if.regs         cfg
);

  //==========================================================================
  // Decoder constants
  //==========================================================================

  localparam int              DEC_SZ   = 1 << DEC_WD;  // One bit per byte offset
  localparam logic [DEC_SZ-1:0] BASE_REG = DEC_SZ'(1);

  // One-hot position of each register
  localparam logic [DEC_SZ-1:0] ADDR_D  = BASE_REG << REG_ADDR_OFS;
  localparam logic [DEC_SZ-1:0] CNT_D   = BASE_REG << REG_CNT_OFS;
  localparam logic [DEC_SZ-1:0] TRACE_D = BASE_REG << REG_TRACE_OFS;
  localparam logic [DEC_SZ-1:0] REG_MAP = ADDR_D | CNT_D | TRACE_D;  // Mapped offsets

  logic              reg_sel;      // Access falls in the probe window
  logic [DEC_WD-1:0] reg_addr;     // Byte offset inside the window
  logic [DEC_SZ-1:0] reg_dec;      // One-hot offset, zero if unmapped
  logic              reg_write;
  logic              reg_read;
  logic [DEC_SZ-1:0] reg_wr;
  logic [DEC_SZ-1:0] reg_rd;
  logic [PER_DW-1:0] addr_reg;     // Target address register

  //==========================================================================
  // Address decode
  //==========================================================================

  // per_addr is a word address, so the base drops one bit
  assign reg_sel   = per_en & (per_addr[PER_AW-1:DEC_WD-1] == BASE_ADDR[PER_AW:DEC_WD]);
  assign reg_addr  = {per_addr[DEC_WD-2:0], 1'b0};
  assign reg_dec   = (BASE_REG << reg_addr) & REG_MAP;

  // Any byte enable counts as a write
  assign reg_write =  |per_we & reg_sel;
  assign reg_read  = ~|per_we & reg_sel;

  assign reg_wr    = reg_dec & {DEC_SZ{reg_write}};
  assign reg_rd    = reg_dec & {DEC_SZ{reg_read}};

  //==========================================================================
  // Registers
  //==========================================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      addr_reg <= '0;
    end else if (reg_wr[REG_ADDR_OFS]) begin
      addr_reg <= per_din;
    end
  end

  // Word address toward the DMA port, bit 15 only reads back
  assign cfg.target_addr = addr_reg[DMA_AW-1:0];

  // Counter lives in the engine, the write is just forwarded
  assign cfg.cnt_load    = reg_wr[REG_CNT_OFS];
  assign cfg.cnt_value   = per_din;

  //==========================================================================
  // Read mux
  //==========================================================================

  // AND-OR mux, zero when nothing is read
  assign per_dout = ({PER_DW{reg_rd[REG_ADDR_OFS]}}  & addr_reg)           |
                    ({PER_DW{reg_rd[REG_CNT_OFS]}}   & cfg.cnt_remaining)  |
                    ({PER_DW{reg_rd[REG_TRACE_OFS]}} & PER_DW'(cfg.trace));

endmodule

/* src/dma_probe_top.sv */
module dma_probe_top import per_bus_pkg::*, dma_pkg::*; #(
  parameter logic [PER_AW:0] BASE_ADDR = 15'h0070,  // Probe window, byte address
  parameter int              DEC_WD    = 3,         // Window size as 2**DEC_WD bytes
  parameter int              RAM_AW    = 8          // RAM word address width
) (
  input  logic              mclk,
  input  logic              puc_rst,

  // Peripheral bus
  input  logic [PER_AW-1:0] per_addr,
  input  logic [PER_DW-1:0] per_din,
  input  logic              per_en,
  input  logic [1:0]        per_we,
  output logic [PER_DW-1:0] per_dout,

  // CPU side of the RAM
  input  logic [RAM_AW-1:0] cpu_addr,
  input  logic              cpu_en,
  input  logic [1:0]        cpu_we,
  input  logic [15:0]       cpu_din,
  output logic [15:0]       cpu_dout,

  // DMA request, visible for observation
  output logic [DMA_AW-1:0] dma_addr,
  output logic              dma_en
);

  dma_if       dma_bus ();         // Engine to RAM
  probe_cfg_if cfg_bus ();         // Registers to engine

  //==========================================================================
  // Instances
  //==========================================================================

  dma_probe_regs #(
    .BASE_ADDR (BASE_ADDR),
    .DEC_WD    (DEC_WD)
  ) regs_i (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (per_dout),
    .cfg      (cfg_bus.regs)
  );

  dma_probe_engine engine_i (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .cfg     (cfg_bus.engine),
    .dma     (dma_bus.engine)
  );

  banked_ram #(
    .RAM_AW (RAM_AW)
  ) ram_i (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .cpu_addr (cpu_addr),
    .cpu_en   (cpu_en),
    .cpu_we   (cpu_we),
    .cpu_din  (cpu_din),
    .cpu_dout (cpu_dout),
    .dma      (dma_bus.ram)
  );

  assign dma_addr = dma_bus.addr;  // Request brought out as plain ports
  assign dma_en   = dma_bus.en;

endmodule

/* src/per_bus_pkg.sv */
package per_bus_pkg;

  //==========================================================================
  // Peripheral bus geometry
  //==========================================================================

  localparam int PER_AW = 14;      // Word address, byte address bits 14:1
  localparam int PER_DW = 16;      // Data path width

  //==========================================================================
  // Probe register map
  //==========================================================================

  // Byte offsets from the probe base address
  localparam int REG_ADDR_OFS  = 0;  // Target word address
  localparam int REG_CNT_OFS   = 2;  // Start delay, reads back what is left
  localparam int REG_TRACE_OFS = 4;  // Stall pattern of the last burst

  // Offsets stay even because the decoder drops byte address bit 0

endpackage

/* src/probe_cfg_if.sv */
interface probe_cfg_if import per_bus_pkg::*, dma_pkg::*; ();

  logic [DMA_AW-1:0] target_addr;    // Word address the burst hits
  logic              cnt_load;       // Single cycle pulse on a CNT write
  logic [PER_DW-1:0] cnt_value;      // New delay, valid with cnt_load
  logic [PER_DW-1:0] cnt_remaining;  // Delay left, for readback
  trace_t            trace;          // Stall flags for readback

  // Register block side
  modport regs (
    output target_addr,
    output cnt_load,
    output cnt_value,
    input  cnt_remaining,
    input  trace
  );

  // Engine side
  modport engine (
    input  target_addr,
    input  cnt_load,
    input  cnt_value,
    output cnt_remaining,
    output trace
  );

endinterface
